//--- hdl/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry
`define DC_WAYS 2
`define DC_SETS 16

// set index width, log2 of DC_SETS
`define DC_IDX_W 4

// bus widths
`define DC_ADDR_W 32
`define DC_DATA_W 32

`endif

//--- hdl/dcache_pkg.sv
`include "dcache_macros.svh"
`default_nettype none

package dcache_pkg;

  typedef logic [`DC_ADDR_W-1:0] addr_t;
  typedef logic [`DC_DATA_W-1:0] word_t;

  // address bits 5..2
  typedef logic [`DC_IDX_W-1:0] idx_t;

  // address bits 31..6, one-word lines leave no line offset
  typedef logic [`DC_ADDR_W-`DC_IDX_W-3:0] tag_t;

  // one bit per way, one-hot
  typedef logic [`DC_WAYS-1:0] way_sel_t;

  typedef enum logic [2:0] {
    LD_B  = 3'd0,
    LD_BU = 3'd1,
    LD_H  = 3'd2,
    LD_HU = 3'd3,
    LD_W  = 3'd4
  } ld_type_t;

  typedef enum logic [1:0] {
    RF_IDLE   = 2'd0,
    RF_SETUP  = 2'd1,
    RF_ACCESS = 2'd2,
    RF_RESP   = 2'd3
  } refill_state_t;

endpackage

`default_nettype wire

//--- hdl/dcache_req_stage.sv
`include "dcache_macros.svh"
`default_nettype none

module dcache_req_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid_i,
  input  dcache_pkg::addr_t   req_addr_i,
  input  dcache_pkg::ld_type_t req_type_i,
  output logic                req_ready_o,
  input  logic                stall_i,
  output dcache_pkg::idx_t    lk_idx_o,
  output dcache_pkg::tag_t    lk_tag_o,
  output logic                lk_valid_o,
  output logic                lk_uncached_o,
  output dcache_pkg::ld_type_t lk_type_o,
  output logic [1:0]          lk_off_o
);

  import dcache_pkg::*;

  logic accept;
  idx_t idx_q;

  assign req_ready_o = !stall_i;
  assign accept      = req_valid_i && req_ready_o;

  // while stalled the ways keep reading the set of the load in flight
  assign lk_idx_o = stall_i ? idx_q : req_addr_i[`DC_IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lk_valid_o <= 1'b0;
    end else begin
      lk_valid_o <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      idx_q         <= req_addr_i[`DC_IDX_W+1:2];
      lk_tag_o      <= req_addr_i[`DC_ADDR_W-1:`DC_IDX_W+2];
      lk_type_o     <= req_type_i;
      lk_off_o      <= req_addr_i[1:0];
      // top half of the map bypasses the cache
      lk_uncached_o <= req_addr_i[`DC_ADDR_W-1];
    end
  end

endmodule

`default_nettype wire

//--- hdl/dcache_way.sv
`include "dcache_macros.svh"
`default_nettype none

module dcache_way (
  input  logic             clk,
  input  logic             rst_n,
  input  dcache_pkg::idx_t rd_idx_i,
  input  dcache_pkg::tag_t cmp_tag_i,
  output logic             hit_o,
  output dcache_pkg::word_t data_o,
  input  logic             fill_we_i,
  input  dcache_pkg::idx_t fill_idx_i,
  input  dcache_pkg::tag_t fill_tag_i,
  input  dcache_pkg::word_t fill_data_i
);

  import dcache_pkg::*;

  logic [`DC_SETS-1:0] valid_q;
  tag_t  tag_ram  [`DC_SETS];
  word_t data_ram [`DC_SETS];

  // read port registers
  logic  rd_valid_q;
  tag_t  rd_tag_q;
  word_t rd_data_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q    <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= valid_q[rd_idx_i];
      if (fill_we_i) begin
        valid_q[fill_idx_i] <= 1'b1;
      end
    end
  end

  // read before write on a shared set
  always_ff @(posedge clk) begin
    rd_tag_q  <= tag_ram[rd_idx_i];
    rd_data_q <= data_ram[rd_idx_i];
    if (fill_we_i) begin
      tag_ram[fill_idx_i]  <= fill_tag_i;
      data_ram[fill_idx_i] <= fill_data_i;
    end
  end

  // compare in the cycle after the read
  assign hit_o  = rd_valid_q && (rd_tag_q == cmp_tag_i);
  assign data_o = rd_data_q;

endmodule

`default_nettype wire

//--- hdl/dcache_hit_merge.sv
`include "dcache_macros.svh"
`default_nettype none

module dcache_hit_merge (
  input  dcache_pkg::way_sel_t              way_hit_i,
  input  dcache_pkg::word_t [`DC_WAYS-1:0]  way_data_i,
  input  logic                              lk_valid_i,
  input  logic                              lk_uncached_i,
  input  dcache_pkg::ld_type_t              lk_type_i,
  input  logic [1:0]                        lk_off_i,
  input  logic                              fill_valid_i,
  input  dcache_pkg::word_t                 fill_data_i,
  output logic                              rsp_valid_o,
  output dcache_pkg::word_t                 rsp_data_o
);

  import dcache_pkg::*;

  word_t word;
  word_t shifted;

  // refill word wins, hits are stale while a refill responds
  always_comb begin
    if (fill_valid_i) begin
      word = fill_data_i;
    end else begin
      word = '0;
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (way_hit_i[w]) begin
          word = word | way_data_i[w];
        end
      end
    end
  end

  // byte lane down to bit 0
  assign shifted = word >> {lk_off_i, 3'b000};

  always_comb begin
    case (lk_type_i)
      LD_B:    rsp_data_o = {{24{shifted[7]}}, shifted[7:0]};
      LD_BU:   rsp_data_o = {24'b0, shifted[7:0]};
      LD_H:    rsp_data_o = {{16{shifted[15]}}, shifted[15:0]};
      LD_HU:   rsp_data_o = {16'b0, shifted[15:0]};
      default: rsp_data_o = shifted;
    endcase
  end

  // uncached loads never answer from the ways
  assign rsp_valid_o = fill_valid_i || (lk_valid_i && !lk_uncached_i && (|way_hit_i));

endmodule

`default_nettype wire

//--- hdl/dcache_refill_fsm.sv
`include "dcache_macros.svh"
`default_nettype none

module dcache_refill_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 lk_valid_i,
  input  logic                 lk_uncached_i,
  input  dcache_pkg::tag_t     lk_tag_i,
  input  dcache_pkg::idx_t     lk_idx_i,
  input  logic                 any_hit_i,
  output logic                 stall_o,
  output dcache_pkg::way_sel_t fill_we_o,
  output dcache_pkg::tag_t     fill_tag_o,
  output dcache_pkg::word_t    fill_data_o,
  output logic                 fill_valid_o,
  output logic                 psel_o,
  output logic                 penable_o,
  output dcache_pkg::addr_t    paddr_o,
  input  dcache_pkg::word_t    prdata_i,
  input  logic                 pready_i
);

  import dcache_pkg::*;

  refill_state_t state_q;
  refill_state_t state_d;
  addr_t addr_q;
  logic  unc_q;
  word_t data_q;
  logic [$clog2(`DC_WAYS)-1:0] victim_q;
  logic  start;
  logic  done;

  assign start = lk_valid_i && (lk_uncached_i || !any_hit_i);
  assign done  = (state_q == RF_ACCESS) && pready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RF_IDLE: begin
        if (start) begin
          state_d = RF_SETUP;
        end
      end
      RF_SETUP: begin
        state_d = RF_ACCESS;
      end
      RF_ACCESS: begin
        if (pready_i) begin
          state_d = RF_RESP;
        end
      end
      default: begin
        state_d = RF_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= RF_IDLE;
      victim_q <= '0;
    end else begin
      state_q <= state_d;
      // round robin, only cached fills move it
      if (done && !unc_q) begin
        victim_q <= (victim_q == `DC_WAYS - 1) ? '0 : victim_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == RF_IDLE) && start) begin
      addr_q <= {lk_tag_i, lk_idx_i, 2'b00};
      unc_q  <= lk_uncached_i;
    end
    if (done) begin
      data_q <= prdata_i;
    end
  end

  // stall from the miss cycle up to the response cycle
  assign stall_o = (state_q == RF_IDLE) ? start : (state_q != RF_RESP);

  // APB master, read only
  assign psel_o    = (state_q == RF_SETUP) || (state_q == RF_ACCESS);
  assign penable_o = (state_q == RF_ACCESS);
  assign paddr_o   = addr_q;

  // way write on the completing edge
  assign fill_we_o    = (done && !unc_q) ? (way_sel_t'(1'b1) << victim_q) : '0;
  assign fill_tag_o   = addr_q[`DC_ADDR_W-1:`DC_IDX_W+2];
  assign fill_data_o  = (state_q == RF_ACCESS) ? prdata_i : data_q;
  assign fill_valid_o = (state_q == RF_RESP);

endmodule

`default_nettype wire

//--- hdl/dcache_rport.sv
`include "dcache_macros.svh"
`default_nettype none

module dcache_rport (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_valid_i,
  input  dcache_pkg::addr_t    req_addr_i,
  input  dcache_pkg::ld_type_t req_type_i,
  output logic                 req_ready_o,
  output logic                 rsp_valid_o,
  output dcache_pkg::word_t    rsp_data_o,
  output logic                 psel_o,
  output logic                 penable_o,
  output dcache_pkg::addr_t    paddr_o,
  input  dcache_pkg::word_t    prdata_i,
  input  logic                 pready_i
);

  import dcache_pkg::*;

  // lookup from the request stage
  idx_t     lk_idx;
  tag_t     lk_tag;
  logic     lk_valid;
  logic     lk_uncached;
  ld_type_t lk_type;
  logic [1:0] lk_off;

  way_sel_t way_hit;
  word_t [`DC_WAYS-1:0] way_data;

  // refill path back into the ways
  way_sel_t fill_we;
  idx_t     fill_idx;
  tag_t     fill_tag;
  word_t    fill_data;
  logic     fill_valid;
  logic     stall;

  assign fill_idx = paddr_o[`DC_IDX_W+1:2];

  dcache_req_stage u_req_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_type_i    (req_type_i),
    .req_ready_o   (req_ready_o),
    .stall_i       (stall),
    .lk_idx_o      (lk_idx),
    .lk_tag_o      (lk_tag),
    .lk_valid_o    (lk_valid),
    .lk_uncached_o (lk_uncached),
    .lk_type_o     (lk_type),
    .lk_off_o      (lk_off)
  );

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    dcache_way u_way (
      .clk         (clk),
      .rst_n       (rst_n),
      .rd_idx_i    (lk_idx),
      .cmp_tag_i   (lk_tag),
      .hit_o       (way_hit[w]),
      .data_o      (way_data[w]),
      .fill_we_i   (fill_we[w]),
      .fill_idx_i  (fill_idx),
      .fill_tag_i  (fill_tag),
      .fill_data_i (fill_data)
    );
  end

  dcache_hit_merge u_hit_merge (
    .way_hit_i     (way_hit),
    .way_data_i    (way_data),
    .lk_valid_i    (lk_valid),
    .lk_uncached_i (lk_uncached),
    .lk_type_i     (lk_type),
    .lk_off_i      (lk_off),
    .fill_valid_i  (fill_valid),
    .fill_data_i   (fill_data),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_data_o    (rsp_data_o)
  );

  dcache_refill_fsm u_refill_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .lk_valid_i    (lk_valid),
    .lk_uncached_i (lk_uncached),
    .lk_tag_i      (lk_tag),
    .lk_idx_i      (lk_idx),
    .any_hit_i     (|way_hit),
    .stall_o       (stall),
    .fill_we_o     (fill_we),
    .fill_tag_o    (fill_tag),
    .fill_data_o   (fill_data),
    .fill_valid_o  (fill_valid),
    .psel_o        (psel_o),
    .penable_o     (penable_o),
    .paddr_o       (paddr_o),
    .prdata_i      (prdata_i),
    .pready_i      (pready_i)
  );

endmodule

`default_nettype wire

//--- tb/dcache_rport_assertions.sv
`default_nettype none

module dcache_rport_assertions (
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic        req_ready_o,
  input wire logic        rsp_valid_o,
  input wire logic        psel_o,
  input wire logic        penable_o,
  input wire logic [31:0] paddr_o,
  input wire logic        pready_i
);

  timeunit 1ns;
  timeprecision 1ns;

  // count of failed assertions
  int fail_cnt = 0;

  // address holds from setup until the completing edge
  addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (psel_o && !(penable_o && pready_i)) |=> (psel_o && $stable(paddr_o)))
    else begin
      fail_cnt++;
      $error("paddr_o changed during an APB transfer");
    end

  // setup phase is always followed by the access phase
  setup_to_access: assert property (@(posedge clk) disable iff (!rst_n)
    (psel_o && !penable_o) |=> (psel_o && penable_o))
    else begin
      fail_cnt++;
      $error("APB setup phase not followed by access phase");
    end

  enable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(penable_o) |-> $past(psel_o && !penable_o))
    else begin
      fail_cnt++;
      $error("penable_o rose without a setup cycle");
    end

  // ready stays low from the miss cycle through the access phase
  ready_low_in_transfer: assert property (@(posedge clk) disable iff (!rst_n)
    psel_o |-> (!req_ready_o && $past(!req_ready_o)))
    else begin
      fail_cnt++;
      $error("req_ready_o high while a miss transfer runs");
    end

  // ready comes back only together with the miss response
  ready_held_low: assert property (@(posedge clk) disable iff (!rst_n)
    !req_ready_o |=> (!req_ready_o || rsp_valid_o))
    else begin
      fail_cnt++;
      $error("req_ready_o rose before the miss response");
    end

  // a miss response is a single cycle pulse
  miss_rsp_single: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid_o && !$past(req_ready_o)) |=> !rsp_valid_o)
    else begin
      fail_cnt++;
      $error("rsp_valid_o high for two cycles after a miss");
    end

endmodule

`default_nettype wire

//--- tb/dcache_rport_tb.sv
`default_nettype none

module dcache_rport_tb;

  timeunit 1ns;
  timeprecision 1ns;

  import dcache_pkg::*;

  localparam int N_LOADS = 63;

  logic     clk = 1'b0;
  logic     rst_n = 1'b0;
  logic     req_valid_i = 1'b0;
  addr_t    req_addr_i = '0;
  ld_type_t req_type_i = LD_W;
  word_t    prdata_i = '0;
  logic     pready_i = 1'b0;
  logic     req_ready_o;
  logic     rsp_valid_o;
  word_t    rsp_data_o;
  logic     psel_o;
  logic     penable_o;
  addr_t    paddr_o;

  int    errors = 0;
  int    tests_failed = 0;
  int    apb_count = 0;
  addr_t apb_last = '0;
  int    wait_left = 0;
  int    wait_new;

  // reference model of the tag state
  logic  mdl_valid [2][16];
  tag_t  mdl_tag [2][16];
  int    mdl_victim = 0;
  addr_t burst_addr [3];

  dcache_rport u_dcache_rport (.*);

  bind dcache_rport dcache_rport_assertions u_assert (
    .clk(clk), .rst_n(rst_n), .req_ready_o(req_ready_o), .rsp_valid_o(rsp_valid_o),
    .psel_o(psel_o), .penable_o(penable_o), .paddr_o(paddr_o), .pready_i(pready_i)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  function automatic word_t mem_word(input addr_t a);
    return (a * 32'h9E37_79B1) ^ 32'h5A5A_1234;
  endfunction

  // expected load result from the lane rules
  function automatic word_t lane(input word_t wd, input logic [1:0] off, input ld_type_t t);
    logic [7:0]  b;
    logic [15:0] h;
    case (off)
      2'd0: b = wd[7:0];
      2'd1: b = wd[15:8];
      2'd2: b = wd[23:16];
      default: b = wd[31:24];
    endcase
    h = off[1] ? wd[31:16] : wd[15:0];
    case (t)
      LD_B: return {{24{b[7]}}, b};
      LD_BU: return {24'h0, b};
      LD_H: return {{16{h[15]}}, h};
      LD_HU: return {16'h0, h};
      default: return wd;
    endcase
  endfunction

  // APB slave with 0 to 3 wait states
  always @(posedge clk) begin
    if (!rst_n) begin
      pready_i <= 1'b0;
    end else if (psel_o && !penable_o) begin
      wait_new = int'($urandom_range(3, 0));
      wait_left <= wait_new;
      pready_i <= (wait_new == 0);
      prdata_i <= mem_word(paddr_o);
    end else if (psel_o && penable_o && !pready_i) begin
      wait_left <= wait_left - 1;
      pready_i <= (wait_left == 1);
    end else if (psel_o && penable_o && pready_i) begin
      pready_i <= 1'b0;
      apb_count++;
      apb_last = paddr_o;
    end
  end

  task automatic do_load(input addr_t a, input ld_type_t t, output word_t d, output int lat);
    req_valid_i <= 1'b1;
    req_addr_i <= a;
    req_type_i <= t;
    do @(posedge clk); while (!req_ready_o);
    req_valid_i <= 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!rsp_valid_o && lat < 20);
    d = rsp_data_o;
    if (!rsp_valid_o) begin
      $display("no response for load at %h", a);
      errors++;
    end
  endtask

  task automatic check_load(input addr_t a, input ld_type_t t);
    word_t got;
    word_t exp;
    int    lat;
    int    apb0;
    logic  hit;
    idx_t  ix;
    tag_t  tg;
    ix = a[5:2];
    tg = a[31:6];
    hit = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (!a[31] && mdl_valid[w][ix] && mdl_tag[w][ix] == tg) begin
        hit = 1'b1;
      end
    end
    apb0 = apb_count;
    exp = lane(mem_word({a[31:2], 2'b00}), a[1:0], t);
    do_load(a, t, got, lat);
    if (got !== exp) begin
      $display("mismatch rsp_data_o at %h: got %h expected %h", a, got, exp);
      errors++;
    end
    if (hit && lat != 1) begin
      $display("hit at %h answered after %0d cycles instead of 1", a, lat);
      errors++;
    end
    if ((apb_count - apb0) != (hit ? 0 : 1)) begin
      $display("mismatch apb_transfers at %h: got %h expected %h", a,
               apb_count - apb0, hit ? 0 : 1);
      errors++;
    end
    if (!hit && apb_last !== {a[31:2], 2'b00}) begin
      $display("mismatch paddr_o: got %h expected %h", apb_last, {a[31:2], 2'b00});
      errors++;
    end
    if (!hit && !a[31]) begin
      mdl_valid[mdl_victim][ix] = 1'b1;
      mdl_tag[mdl_victim][ix] = tg;
      mdl_victim = (mdl_victim + 1) % 2;
    end
  endtask

  // back to back loads answered one cycle later
  task automatic hit_burst;
    word_t exp;
    for (int i = 0; i <= 3; i++) begin
      if (i < 3) begin
        req_valid_i <= 1'b1;
        req_addr_i <= burst_addr[i];
        req_type_i <= LD_W;
      end else begin
        req_valid_i <= 1'b0;
      end
      @(posedge clk);
      if (i < 3 && !req_ready_o) begin
        $display("burst load %0d was not accepted", i);
        errors++;
      end
      if (i > 0) begin
        exp = mem_word(burst_addr[i-1]);
        if (!rsp_valid_o) begin
          $display("no response in cycle after burst load %0d", i - 1);
          errors++;
        end else if (rsp_data_o !== exp) begin
          $display("mismatch rsp_data_o: got %h expected %h", rsp_data_o, exp);
          errors++;
        end
      end
    end
  endtask

  task automatic end_test(input int num, input string name, input int err0);
    $display("test %0d %s: %0d errors", num, name, errors - err0);
    if (errors != err0) begin
      tests_failed++;
    end
  endtask

  initial begin
    #(N_LOADS * 10 * 100);
    $display("watchdog expired, the loads stopped making progress");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int    e0;
    int    apb0;
    addr_t ra;
    addr_t lb;
    void'($urandom(28));
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < 16; s++) begin
        mdl_valid[w][s] = 1'b0;
        mdl_tag[w][s] = '0;
      end
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    e0 = errors;
    check_load(32'h0000_0100, LD_W);
    check_load(32'h0000_0104, LD_W);
    check_load(32'h0000_0108, LD_W);
    end_test(1, "cold miss", e0);

    e0 = errors;
    check_load(32'h0000_0100, LD_W);
    burst_addr[0] = 32'h0000_0100;
    burst_addr[1] = 32'h0000_0104;
    burst_addr[2] = 32'h0000_0108;
    apb0 = apb_count;
    hit_burst();
    if (apb_count != apb0) begin
      $display("mismatch apb_transfers in burst: got %h expected 0", apb_count - apb0);
      errors++;
    end
    end_test(2, "hits", e0);

    e0 = errors;
    check_load(32'h8000_0040, LD_W);
    check_load(32'h8000_0040, LD_W);
    end_test(3, "uncached", e0);

    e0 = errors;
    // two words so that every lane is seen with both sign bits
    for (int k = 0; k < 2; k++) begin
      lb = (k == 0) ? 32'h0000_0200 : 32'h0000_0214;
      for (int off = 0; off < 4; off++) begin
        check_load(lb | off, LD_B);
        check_load(lb | off, LD_BU);
      end
      for (int off = 0; off < 4; off += 2) begin
        check_load(lb | off, LD_H);
        check_load(lb | off, LD_HU);
      end
    end
    end_test(4, "lanes", e0);

    e0 = errors;
    check_load(32'h0000_1010, LD_W);
    check_load(32'h0000_2010, LD_W);
    check_load(32'h0000_3010, LD_W);
    check_load(32'h0000_1010, LD_W);
    check_load(32'h0000_2010, LD_W);
    check_load(32'h0000_3010, LD_W);
    end_test(5, "eviction", e0);

    e0 = errors;
    for (int i = 0; i < 24; i++) begin
      ra = ($urandom_range(1, 0) == 1) ? 32'h8000_0000 : 32'h0;
      ra = ra | ($urandom & 32'h0000_00FC);
      check_load(ra, LD_W);
    end
    end_test(6, "random wait states", e0);

    @(posedge clk);
    $display("tests 6, failed %0d, errors %0d, assertion failures %0d",
             tests_failed, errors, u_dcache_rport.u_assert.fail_cnt);
    if (errors == 0 && u_dcache_rport.u_assert.fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache_rport.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_req_stage.sv
hdl/dcache_way.sv
hdl/dcache_hit_merge.sv
hdl/dcache_refill_fsm.sv
hdl/dcache_rport.sv
tb/dcache_rport_assertions.sv
tb/dcache_rport_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the read port testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f dcache_rport.f \
  --top-module dcache_rport_tb -o sim_dcache_rport &&
./obj_dir/sim_dcache_rport +verilator+error+limit+1000 | tee /dev/stderr | grep -q "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
